// File: source/core_pkg.sv
/*
  shared constants and types for the core clock domain
  ROM depth and divider period are fixed, nothing here is meant to be overridden
  address regions are decoded on the top byte of the APB address only
*/

package core_pkg;

  ////////////////////////////////////////////////////////////
  // APB host bus

  localparam int addr_w = 32;
  localparam int data_w = 32;

  // top address byte of each region
  localparam logic [7:0] rom_region  = 8'h00;
  localparam logic [7:0] ctrl_region = 8'hF8;

  ////////////////////////////////////////////////////////////
  // program ROM

  localparam int rom_depth = 8192;
  localparam int rom_aw    = 13;
  // cpu only sees the low 12 bits of each word
  localparam int rom_dw    = 12;
  // host delivers 16-bit words, bytes swapped
  localparam int load_dw   = 16;

  ////////////////////////////////////////////////////////////
  // clock enable divider

  // 1001 cycles per single-rate tick
  localparam int div_reload = 1000;
  localparam int div_half   = 500;

  ////////////////////////////////////////////////////////////
  // controller keys

  localparam int key_w     = 16;
  localparam int key_a_bit = 4;
  localparam int key_b_bit = 5;
  localparam int key_y_bit = 7;

  ////////////////////////////////////////////////////////////
  // enums

  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_respond
  } apb_state_e;

  typedef enum logic [2:0] {
    op_none,
    op_rom_write,
    op_ctrl_write,
    op_ctrl_read,
    op_bad
  } host_op_e;

endpackage

// File: source/rom_load_if.sv
/*
  ROM load path from the host bus to the program memory
  no handshake, the memory takes every write in the cycle wr_en is high
  load_count is the number of words accepted since reset
*/

interface rom_load_if;

  // one write per cycle, qualified by wr_en
  logic                          wr_en;
  // word index, already shifted down from the byte address
  logic [core_pkg::rom_aw-1:0]   wr_index;
  // raw host word, swap happens in the memory
  logic [core_pkg::load_dw-1:0]  wr_word;

  // upper half of the control register on a read
  logic [core_pkg::data_w/2-1:0] load_count;

  // bus side
  modport host (
    output wr_en,
    output wr_index,
    output wr_word,
    input  load_count
  );

  // memory side, owns the word counter
  modport rom (
    input  wr_en,
    input  wr_index,
    input  wr_word,
    output load_count
  );

endinterface

// File: source/host_bus_ctrl.sv
/*
  APB slave for ROM loading and the run register
  every transfer gets exactly one wait state, pready is high in the second access cycle
  prdata and pslverr are only meaningful while pready is high
  the master must hold paddr, pwrite and pwdata for the whole transfer
*/

module host_bus_ctrl (
  input  logic                        clk_32_768,
  input  logic                        rst,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [core_pkg::addr_w-1:0] paddr,
  input  logic [core_pkg::data_w-1:0] pwdata,
  output logic [core_pkg::data_w-1:0] prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic                        run,
  rom_load_if.host                    load
);

  core_pkg::apb_state_e state;
  core_pkg::host_op_e   op;
  logic [core_pkg::data_w-1:0] ctrl_word;

  // region decode on the top address byte
  function automatic core_pkg::host_op_e decode_op(
    input logic [core_pkg::addr_w-1:0] addr,
    input logic                        write
  );
    logic [7:0] region;
    region = addr[core_pkg::addr_w-1 -: 8];
    if (region == core_pkg::rom_region) begin
      // ROM is write only from the host
      return write ? core_pkg::op_rom_write : core_pkg::op_bad;
    end
    if (region == core_pkg::ctrl_region) begin
      return write ? core_pkg::op_ctrl_write : core_pkg::op_ctrl_read;
    end
    return core_pkg::op_bad;
  endfunction

  ////////////////////////////////////////////////////////////
  // transfer FSM

  // decode once in setup, count the wait in access, answer in respond
  always_ff @(posedge clk_32_768) begin
    if (rst) begin
      state   <= core_pkg::st_idle;
      op      <= core_pkg::op_none;
      pslverr <= 1'b0;
      run     <= 1'b0;
    end else begin
      case (state)
        core_pkg::st_idle: begin
          if (psel && !penable) begin
            op    <= decode_op(paddr, pwrite);
            state <= core_pkg::st_access;
          end
        end
        core_pkg::st_access: begin
          // first access cycle is the wait state
          pslverr <= (op == core_pkg::op_bad);
          state   <= core_pkg::st_respond;
        end
        core_pkg::st_respond: begin
          if (op == core_pkg::op_ctrl_write) begin
            run <= pwdata[0];
          end
          pslverr <= 1'b0;
          op      <= core_pkg::op_none;
          state   <= core_pkg::st_idle;
        end
        default: state <= core_pkg::st_idle;
      endcase
    end
  end

  assign pready = (state == core_pkg::st_respond);

  ////////////////////////////////////////////////////////////
  // read data

  // run in bit 0, word count in the top half
  always_comb begin
    ctrl_word = '0;
    ctrl_word[0] = run;
    ctrl_word[core_pkg::data_w-1 -: core_pkg::data_w/2] = load.load_count;
  end

  // captured during the wait so it lines up with pready
  always_ff @(posedge clk_32_768) begin
    if (state == core_pkg::st_access) begin
      prdata <= (op == core_pkg::op_ctrl_read) ? ctrl_word : '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // ROM load port

  // write lands in the pready cycle
  assign load.wr_en    = (state == core_pkg::st_respond) && (op == core_pkg::op_rom_write);
  // byte address to word index
  assign load.wr_index = paddr[core_pkg::rom_aw+1:2];
  assign load.wr_word  = pwdata[core_pkg::load_dw-1:0];

  // protocol checks
  a_penable_needs_psel: assert property (
    @(posedge clk_32_768) disable iff (rst) penable |-> psel
  ) else $error("penable high without psel");

  a_addr_stable: assert property (
    @(posedge clk_32_768) disable iff (rst) (state != core_pkg::st_idle) |-> $stable(paddr)
  ) else $error("paddr changed during a waited transfer");

endmodule

// File: source/program_rom.sv
/*
  8192 x 12 program memory
  load words arrive with their two bytes swapped, upper 4 bits are dropped
  cpu read is registered, one edge from rom_addr to rom_data
  no read-during-write bypass, a same-index read returns the old word
*/

module program_rom (
  input  logic                        clk_32_768,
  input  logic                        rst,
  input  logic [core_pkg::rom_aw-1:0] rom_addr,
  output logic [core_pkg::rom_dw-1:0] rom_data,
  rom_load_if.rom                     load
);

  logic [core_pkg::rom_dw-1:0]  mem [core_pkg::rom_depth];
  logic [core_pkg::load_dw-1:0] swapped;
  logic [core_pkg::data_w/2-1:0] count;

  ////////////////////////////////////////////////////////////
  // load side

  // host sends big-endian words
  assign swapped = {load.wr_word[7:0], load.wr_word[15:8]};

  always_ff @(posedge clk_32_768) begin
    if (load.wr_en) begin
      mem[load.wr_index] <= swapped[core_pkg::rom_dw-1:0];
    end
  end

  // counts accepted writes, rewrites of one index count again
  always_ff @(posedge clk_32_768) begin
    if (rst) begin
      count <= '0;
    end else if (load.wr_en) begin
      count <= count + 1'b1;
    end
  end

  assign load.load_count = count;

  ////////////////////////////////////////////////////////////
  // cpu side

  // block RAM style registered read
  always_ff @(posedge clk_32_768) begin
    rom_data <= mem[rom_addr];
  end

  // a known 13-bit index always lands inside the 8192 words
  a_index_in_range: assert property (
    @(posedge clk_32_768) disable iff (rst)
      load.wr_en |-> !$isunknown(load.wr_index)
  ) else $error("ROM load index unknown, no word addressed");

endmodule

// File: source/tick_gen.sv
/*
  free-running clock enables for the pet cpu
  clk_en once every 1001 cycles, clk_2x_en with it and again 500 cycles later
  first clk_en comes 1001 cycles after reset is released
*/

module tick_gen (
  input  logic clk_32_768,
  input  logic rst,
  output logic clk_en,
  output logic clk_2x_en
);

  typedef logic [$clog2(core_pkg::div_reload+1)-1:0] div_cnt_t;

  div_cnt_t cnt;
  div_cnt_t cnt_dec;

  assign cnt_dec = cnt - 1'b1;

  ////////////////////////////////////////////////////////////
  // down counter with registered pulses

  always_ff @(posedge clk_32_768) begin
    if (rst) begin
      cnt       <= div_cnt_t'(core_pkg::div_reload);
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
    end else begin
      // default no pulse
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
      if (cnt == '0) begin
        cnt       <= div_cnt_t'(core_pkg::div_reload);
        clk_en    <= 1'b1;
        clk_2x_en <= 1'b1;
      end else begin
        cnt <= cnt_dec;
        // mid-period, only the double rate
        if (cnt_dec == div_cnt_t'(core_pkg::div_half)) begin
          clk_2x_en <= 1'b1;
        end
      end
    end
  end

  // single rate must be a subset of double rate
  a_en_in_2x: assert property (
    @(posedge clk_32_768) disable iff (rst) clk_en |-> clk_2x_en
  ) else $error("clk_en without clk_2x_en");

endmodule

// File: source/key_sync.sv
/*
  controller key synchronizer and button mapping
  only keys A, B and Y reach the cpu, active low, top bit held at 0
  three flops from pin to input_k0, the mapped register is the last stage
*/

module key_sync (
  input  logic                       clk_32_768,
  input  logic                       rst,
  input  logic [core_pkg::key_w-1:0] cont1_key,
  output logic [3:0]                 input_k0
);

  // y, b, a from high to low
  logic [2:0] sync_1;
  logic [2:0] sync_2;

  ////////////////////////////////////////////////////////////
  // synchronizer

  always_ff @(posedge clk_32_768) begin
    if (rst) begin
      sync_1   <= '0;
      sync_2   <= '0;
      // nothing pressed
      input_k0 <= 4'b0111;
    end else begin
      sync_1 <= {cont1_key[core_pkg::key_y_bit],
                 cont1_key[core_pkg::key_b_bit],
                 cont1_key[core_pkg::key_a_bit]};
      sync_2 <= sync_1;
      // left, middle, right buttons, pressed reads 0
      input_k0 <= {1'b0, ~sync_2};
    end
  end

endmodule

// File: source/core_host_top.sv
/*
  core clock domain top, host bus, program ROM, clock enables and keys
  the pet cpu sits outside and connects through the rom and enable ports
  cpu_reset_n is the host run bit, low until the host writes run
*/

module core_host_top (
  input  logic                        clk_32_768,
  input  logic                        rst,

  // host APB
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [core_pkg::addr_w-1:0] paddr,
  input  logic [core_pkg::data_w-1:0] pwdata,
  output logic [core_pkg::data_w-1:0] prdata,
  output logic                        pready,
  output logic                        pslverr,

  // pet cpu
  input  logic [core_pkg::rom_aw-1:0] rom_addr,
  output logic [core_pkg::rom_dw-1:0] rom_data,
  output logic                        cpu_reset_n,
  output logic                        clk_en,
  output logic                        clk_2x_en,
  output logic [3:0]                  input_k0,

  // controller 1
  input  logic [core_pkg::key_w-1:0]  cont1_key
);

  rom_load_if load_bus ();

  logic run;

  ////////////////////////////////////////////////////////////
  // host side

  host_bus_ctrl u_host_bus_ctrl (
    .clk_32_768 (clk_32_768),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .run        (run),
    .load       (load_bus.host)
  );

  // run doubles as the cpu reset
  assign cpu_reset_n = run;

  ////////////////////////////////////////////////////////////
  // cpu side

  program_rom u_program_rom (
    .clk_32_768 (clk_32_768),
    .rst        (rst),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data),
    .load       (load_bus.rom)
  );

  tick_gen u_tick_gen (
    .clk_32_768 (clk_32_768),
    .rst        (rst),
    .clk_en     (clk_en),
    .clk_2x_en  (clk_2x_en)
  );

  key_sync u_key_sync (
    .clk_32_768 (clk_32_768),
    .rst        (rst),
    .cont1_key  (cont1_key),
    .input_k0   (input_k0)
  );

endmodule

// File: tb/tb_clock.sv
/*
  testbench clock and reset, period 10
  rst is high for the first two rising edges, then released on an edge
*/

module tb_clock (
  output logic clk_32_768,
  output logic rst
);

  initial begin
    clk_32_768 = 1'b0;
    forever #5 clk_32_768 = ~clk_32_768;
  end

  // synchronous release
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk_32_768);
    rst <= 1'b0;
  end

endmodule

// File: tb/core_host_tb.sv
/*
  testbench for core_host_tb driven by tb/core_host_stim.txt
  run from the project root so the stim path resolves
  inputs change on rising edges, outputs are sampled on falling edges
*/

module core_host_tb;

  localparam int xfer_limit  = 16;
  localparam int pulse_limit = 1100;

  logic        clk_32_768;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [12:0] rom_addr;
  logic [11:0] rom_data;
  logic        cpu_reset_n;
  logic        clk_en;
  logic        clk_2x_en;
  logic [3:0]  input_k0;
  logic [15:0] cont1_key;

  integer seed;
  int     errors;
  int     checks;
  int     test_errors;
  int     tests_run;
  int     tests_failed;
  int     cur_test;
  int     fd;
  int     code;
  int     n;
  string  line;

  tb_clock u_clock (
    .clk_32_768 (clk_32_768),
    .rst        (rst)
  );

  core_host_top uut (
    .clk_32_768  (clk_32_768),
    .rst         (rst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data),
    .cpu_reset_n (cpu_reset_n),
    .clk_en      (clk_en),
    .clk_2x_en   (clk_2x_en),
    .input_k0    (input_k0),
    .cont1_key   (cont1_key)
  );

  ////////////////////////////////////////////////////////////
  // checking and bookkeeping

  task check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task report_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  function automatic string test_name(input int num);
    case (num)
      1:       return "reset state";
      2:       return "rom load and read-back";
      3:       return "control and errors";
      4:       return "clock enables";
      5:       return "key mapping";
      default: return "unnamed";
    endcase
  endfunction

  task close_test();
    if (cur_test != 0) begin
      tests_run++;
      if (test_errors != 0) tests_failed++;
      $display("test %0d %s: %0d errors", cur_test, test_name(cur_test), test_errors);
    end
  endtask

  // low byte swapped to the top, then cut to 12 bits
  function automatic logic [11:0] swap_word(input logic [15:0] w);
    return {w[3:0], w[15:8]};
  endfunction

  ////////////////////////////////////////////////////////////
  // bus and port drivers

  task apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                output logic [31:0] rd, output logic er);
    int  cyc;
    logic done;
    @(posedge clk_32_768);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk_32_768);
    penable <= 1'b1;
    cyc  = 0;
    done = 1'b0;
    // one negedge per access cycle
    while (!done && cyc < xfer_limit) begin
      @(negedge clk_32_768);
      cyc++;
      done = pready;
    end
    rd = prdata;
    er = pslverr;
    if (!done) report_failure($sformatf("no pready within %0d cycles at %h", cyc, addr));
    else check_value(cyc, 2, "access cycle of pready");
    @(posedge clk_32_768);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task rom_check(input logic [12:0] idx, input logic [11:0] exp);
    @(posedge clk_32_768);
    rom_addr <= idx;
    // registered read, one edge later
    @(posedge clk_32_768);
    @(negedge clk_32_768);
    check_value(rom_data, exp, $sformatf("rom_data at index %h", idx));
  endtask

  task fill_rom(input int count, input int base);
    logic [15:0] words [$];
    logic [31:0] rnd;
    logic [31:0] rd;
    logic        er;
    for (int i = 0; i < count; i++) begin
      rnd = $random(seed);
      words.push_back(rnd[15:0]);
      apb_xfer(1'b1, (base + i) * 4, rnd, rd, er);
      check_value(er, 0, "pslverr on ROM fill write");
    end
    for (int i = 0; i < count; i++) rom_check(13'(base + i), swap_word(words[i]));
  endtask

  task reset_check(input logic [3:0] k0_exp);
    @(negedge clk_32_768);
    check_value(pready, 0, "pready after reset");
    check_value(pslverr, 0, "pslverr after reset");
    check_value(clk_en, 0, "clk_en after reset");
    check_value(clk_2x_en, 0, "clk_2x_en after reset");
    check_value(cpu_reset_n, 0, "cpu_reset_n after reset");
    check_value(input_k0, k0_exp, "input_k0 after reset");
  endtask

  ////////////////////////////////////////////////////////////
  // clock enables and keys

  // cycles up to the next clk_2x_en, and whether clk_en came with it
  task measure_gap(output int gap, output logic en);
    logic hit;
    gap = 0;
    hit = 1'b0;
    while (!hit && gap < pulse_limit) begin
      @(negedge clk_32_768);
      gap++;
      hit = clk_2x_en;
      if (clk_en && !clk_2x_en) report_failure("clk_en pulsed without clk_2x_en");
    end
    en = clk_en;
    if (!hit) report_failure("timeout waiting for a clk_2x_en pulse");
  endtask

  task enables_check(input int periods, input int half, input int period);
    int   cyc;
    int   gap;
    logic found;
    logic en;
    cyc   = 0;
    found = 1'b0;
    while (!found && cyc < pulse_limit) begin
      @(negedge clk_32_768);
      cyc++;
      found = clk_en;
    end
    if (!found) begin
      report_failure("timeout waiting for the first clk_en pulse");
    end else begin
      check_value(clk_2x_en, 1, "clk_2x_en with clk_en");
      for (int p = 0; p < periods; p++) begin
        measure_gap(gap, en);
        check_value(gap, half, "cycles to mid-period clk_2x_en");
        check_value(en, 0, "clk_en at mid-period");
        measure_gap(gap, en);
        check_value(gap, period - half, "cycles from mid-period to clk_en");
        check_value(en, 1, "clk_en at end of period");
      end
    end
  endtask

  task keys_check(input int count);
    logic [31:0] rnd;
    logic [15:0] pat;
    logic [3:0]  exp;
    for (int i = 0; i < count; i++) begin
      rnd = $random(seed);
      pat = rnd[15:0];
      @(posedge clk_32_768);
      cont1_key <= pat;
      // three flops from pin to nibble
      repeat (3) @(posedge clk_32_768);
      @(negedge clk_32_768);
      exp = {1'b0, ~pat[7], ~pat[5], ~pat[4]};
      check_value(input_k0, exp, $sformatf("input_k0 for keys %h", pat));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stim line dispatch

  task run_line(input string s);
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] x;
    logic [31:0] rd;
    logic        er;
    int          cnt;
    if (s.len() > 1 && s[0] != "#") begin
      cnt = $sscanf(s, "%c %h %h %h", op, a, d, x);
      if (cnt != 4) begin
        report_failure({"bad line in the stimulus file: ", s});
      end else begin
        case (op)
          "T": begin
            close_test();
            cur_test    = a;
            test_errors = 0;
          end
          "S": reset_check(x[3:0]);
          "W": begin
            apb_xfer(1'b1, a, d, rd, er);
            check_value(er, x, $sformatf("pslverr on write to %h", a));
          end
          "R": begin
            apb_xfer(1'b0, a, 32'h0, rd, er);
            check_value(er, d, $sformatf("pslverr on read of %h", a));
            check_value(rd, x, $sformatf("prdata on read of %h", a));
          end
          "C": rom_check(a[12:0], x[11:0]);
          "P": begin
            @(negedge clk_32_768);
            check_value(cpu_reset_n, x, "cpu_reset_n");
          end
          "F": fill_rom(a, d);
          "E": enables_check(a, d, x);
          "K": keys_check(a);
          default: report_failure({"unknown opcode in the stimulus file: ", s});
        endcase
      end
    end
  endtask

  initial begin
    seed         = 33;
    errors       = 0;
    checks       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = 0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    rom_addr     = '0;
    cont1_key    = '0;
    n = 0;
    while (rst && n < 10) begin
      @(posedge clk_32_768);
      n++;
    end
    if (rst) report_failure("reset was never released");
    fd = $fopen("tb/core_host_stim.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open tb/core_host_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0) run_line(line);
      end
      $fclose(fd);
      close_test();
    end
    $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
source/core_pkg.sv
source/rom_load_if.sv
source/host_bus_ctrl.sv
source/program_rom.sv
source/tick_gen.sv
source/key_sync.sv
source/core_host_top.sv
tb/tb_clock.sv
tb/core_host_tb.sv

// File: Makefile
.PHONY: all run clean

all: run

obj_dir/Vcore_host_tb: vlog.f $(shell cat vlog.f)
	verilator --binary --timing --assert -Wno-fatal --top-module core_host_tb -f vlog.f

# the stim file is read at run time from the project root
run: obj_dir/Vcore_host_tb tb/core_host_stim.txt
	./obj_dir/Vcore_host_tb | tee /dev/stderr | grep -q "^test passed$$"

clean:
	rm -rf obj_dir

// File: tb/core_host_stim.txt
# op addr data expected, hex; T n starts test n, S expects input_k0, P expects cpu_reset_n
# W: expected pslverr  R: data is pslverr, expected prdata  C: rom index, expected rom_data
# F: count, first index  E: periods, half gap, period  K: number of key patterns
T 1 0 0
S 0 0 7
R f8000000 0 00000000
T 2 0 0
W 00000000 00001234 0
W 00000004 0000abcd 0
W 00000010 0000ffff 0
W 00007ffc 00005a3c 0
C 0000 0 412
C 0001 0 dab
C 0004 0 fff
C 1fff 0 c5a
W 00000004 00000021 0
C 0001 0 100
W 00000008 ffff8001 0
C 0002 0 180
F 8 100 0
R f8000000 0 000e0000
T 3 0 0
W f8000000 00000001 0
P 0 0 1
R f8000000 0 000e0001
W f8000000 00000000 0
P 0 0 0
R 10000000 1 00000000
R 00000040 1 00000000
W 20000000 00000001 1
P 0 0 0
R f8000000 0 000e0000
T 4 0 0
E 2 1f4 3e9
T 5 0 0
K 20 0 0
